//--- logic/rv_isa_pkg.sv
package rv_isa_pkg;

    // Architectural sizes fixed by RV32I
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // Major opcodes handled by this pipeline
    // Anything else decodes as illegal
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111
    } opcode_t;

    // funct3 for the OP and OP-IMM groups
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 values
    // Base form for most ops, alternate selects SUB and SRA
    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

endpackage : rv_isa_pkg

//--- logic/core_pkg.sv
package core_pkg;

    // Data word and register index, sized from the ISA
    typedef logic [rv_isa_pkg::XLEN-1:0]       word_t;
    typedef logic [rv_isa_pkg::REG_ADDR_W-1:0] reg_addr_t;

    // ALU operation carried from decode to execute
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        // LUI, operand B straight through
        ALU_PASS_B
    } alu_op_t;

endpackage : core_pkg

//--- logic/issue_if.sv
`timescale 1ns/1ps

interface issue_if import core_pkg::*; ();

    // One decoded instruction, valid for a single cycle
    logic      valid;
    alu_op_t   alu_op;
    // Source indices kept for forwarding compares
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    // Register file values as read in decode
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     imm;
    logic      use_imm;
    reg_addr_t rd_addr;
    logic      rd_we;

    modport decode (
        output valid, alu_op, rs1_addr, rs2_addr, rs1_data, rs2_data,
        output imm, use_imm, rd_addr, rd_we
    );

    modport execute (
        input valid, alu_op, rs1_addr, rs2_addr, rs1_data, rs2_data,
        input imm, use_imm, rd_addr, rd_we
    );

endinterface : issue_if

//--- logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import rv_isa_pkg::*, core_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      insn_valid_i,
    input  word_t     insn_i,
    // Register file read port in result_stage
    output reg_addr_t rf_rs1_addr_o,
    output reg_addr_t rf_rs2_addr_o,
    input  word_t     rf_rs1_data_i,
    input  word_t     rf_rs2_data_i,
    issue_if.decode   issue
);

    opcode_t   opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t rd;
    word_t     i_imm;
    word_t     u_imm;

    alu_op_t   dec_op;
    word_t     dec_imm;
    logic      dec_use_imm;
    logic      dec_legal;

    // Field split
    assign opcode = opcode_t'(insn_i[6:0]);
    assign rd     = insn_i[11:7];
    assign funct3 = insn_i[14:12];
    assign funct7 = insn_i[31:25];

    // I-type sign-extended, U-type upper 20 bits
    assign i_imm = {{20{insn_i[31]}}, insn_i[31:20]};
    assign u_imm = {insn_i[31:12], 12'b0};

    // Source reads go straight from the raw fields
    assign rf_rs1_addr_o = insn_i[19:15];
    assign rf_rs2_addr_o = insn_i[24:20];

    always_comb begin
        dec_op      = ALU_ADD;
        dec_imm     = i_imm;
        dec_use_imm = 1'b0;
        dec_legal   = 1'b0;
        case (opcode)
            OP: begin
                // Only base funct7, or alternate on ADD/SUB and SRL/SRA
                dec_legal = (funct7 == FUNCT7_BASE) ||
                            ((funct7 == FUNCT7_ALT) &&
                             ((funct3 == F3_ADD_SUB) || (funct3 == F3_SRL_SRA)));
                case (funct3)
                    F3_ADD_SUB: dec_op = (funct7 == FUNCT7_ALT) ? ALU_SUB : ALU_ADD;
                    F3_SLL:     dec_op = ALU_SLL;
                    F3_SLT:     dec_op = ALU_SLT;
                    F3_SLTU:    dec_op = ALU_SLTU;
                    F3_XOR:     dec_op = ALU_XOR;
                    F3_SRL_SRA: dec_op = (funct7 == FUNCT7_ALT) ? ALU_SRA : ALU_SRL;
                    F3_OR:      dec_op = ALU_OR;
                    default:    dec_op = ALU_AND;
                endcase
            end
            OP_IMM: begin
                dec_use_imm = 1'b1;
                dec_legal   = 1'b1;
                case (funct3)
                    F3_ADD_SUB: dec_op = ALU_ADD;
                    F3_SLL: begin
                        dec_op    = ALU_SLL;
                        dec_legal = (funct7 == FUNCT7_BASE);
                    end
                    F3_SLT:     dec_op = ALU_SLT;
                    F3_SLTU:    dec_op = ALU_SLTU;
                    F3_XOR:     dec_op = ALU_XOR;
                    F3_SRL_SRA: begin
                        // Upper immediate bits pick the shift kind
                        dec_op    = (funct7 == FUNCT7_ALT) ? ALU_SRA : ALU_SRL;
                        dec_legal = (funct7 == FUNCT7_BASE) || (funct7 == FUNCT7_ALT);
                    end
                    F3_OR:      dec_op = ALU_OR;
                    default:    dec_op = ALU_AND;
                endcase
            end
            LUI: begin
                dec_op      = ALU_PASS_B;
                dec_imm     = u_imm;
                dec_use_imm = 1'b1;
                dec_legal   = 1'b1;
            end
            default: begin
                // Illegal or unsupported, flows through with no write
                dec_legal = 1'b0;
            end
        endcase
    end

    // Control flops
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            issue.valid <= 1'b0;
            issue.rd_we <= 1'b0;
        end else begin
            issue.valid <= insn_valid_i;
            // x0 writes dropped here and nowhere else
            issue.rd_we <= insn_valid_i && dec_legal && (rd != '0);
        end
    end

    // Decoded payload, loaded with each accepted instruction
    always_ff @(posedge clk_i) begin
        if (insn_valid_i) begin
            issue.alu_op   <= dec_op;
            issue.rs1_addr <= rf_rs1_addr_o;
            issue.rs2_addr <= rf_rs2_addr_o;
            issue.rs1_data <= rf_rs1_data_i;
            issue.rs2_data <= rf_rs2_data_i;
            issue.imm      <= dec_imm;
            issue.use_imm  <= dec_use_imm;
            issue.rd_addr  <= rd;
        end
    end

endmodule : decode_stage

//--- logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import core_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    issue_if.execute  issue,
    // Older forwarding source from result_stage
    input  logic      res_we_i,
    input  reg_addr_t res_rd_i,
    input  word_t     res_data_i,
    // Output register, also the newest forwarding source
    output logic      ex_we_o,
    output reg_addr_t ex_rd_o,
    output word_t     ex_data_o
);

    word_t op_a;
    word_t rs2_val;
    word_t op_b;
    word_t alu_res;

    // Newest producer wins: own register, then result stage, then decode read
    function automatic word_t fwd_pick(input reg_addr_t addr, input word_t dec_data);
        word_t val;
        if (ex_we_o && (ex_rd_o == addr)) begin
            val = ex_data_o;
        end else if (res_we_i && (res_rd_i == addr)) begin
            val = res_data_i;
        end else begin
            val = dec_data;
        end
        return val;
    endfunction

    always_comb begin
        op_a    = fwd_pick(issue.rs1_addr, issue.rs1_data);
        rs2_val = fwd_pick(issue.rs2_addr, issue.rs2_data);
        // Immediate replaces rs2 for OP-IMM and LUI
        op_b    = issue.use_imm ? issue.imm : rs2_val;
    end

    // ALU
    always_comb begin
        case (issue.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            // Shift amount is the low 5 bits only
            ALU_SLL:    alu_res = op_a << op_b[4:0];
            ALU_SLT:    alu_res = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   alu_res = word_t'(op_a < op_b);
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SRL:    alu_res = op_a >> op_b[4:0];
            ALU_SRA:    alu_res = word_t'($signed(op_a) >>> op_b[4:0]);
            ALU_OR:     alu_res = op_a | op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ex_we_o <= 1'b0;
        end else begin
            ex_we_o <= issue.valid && issue.rd_we;
        end
    end

    // Result payload held until the next instruction
    always_ff @(posedge clk_i) begin
        if (issue.valid) begin
            ex_rd_o   <= issue.rd_addr;
            ex_data_o <= alu_res;
        end
    end

endmodule : execute_stage

//--- logic/result_stage.sv
`timescale 1ns/1ps

module result_stage import rv_isa_pkg::*, core_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      ex_we_i,
    input  reg_addr_t ex_rd_i,
    input  word_t     ex_data_i,
    // Read ports for decode
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    output word_t     rs1_data_o,
    output word_t     rs2_data_o,
    // Forwarding back to execute
    output logic      res_we_o,
    output reg_addr_t res_rd_o,
    output word_t     res_data_o,
    // Write report at the top level
    output logic      wb_valid_o,
    output reg_addr_t wb_rd_o,
    output word_t     wb_data_o
);

    word_t regs [NUM_REGS];

    // Read with write-through of the write in progress
    function automatic word_t rf_read(input reg_addr_t addr);
        word_t val;
        if (addr == '0) begin
            val = '0;
        end else if (res_we_o && (res_rd_o == addr)) begin
            val = res_data_o;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_comb begin
        rs1_data_o = rf_read(rs1_addr_i);
        rs2_data_o = rf_read(rs2_addr_i);
    end

    // Result register
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            res_we_o <= 1'b0;
        end else begin
            res_we_o <= ex_we_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ex_we_i) begin
            res_rd_o   <= ex_rd_i;
            res_data_o <= ex_data_i;
        end
    end

    // Register file written one edge after the result register
    // Every register reads zero after reset
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (res_we_o) begin
            regs[res_rd_o] <= res_data_o;
        end
    end

    // Same register drives the external report
    assign wb_valid_o = res_we_o;
    assign wb_rd_o    = res_rd_o;
    assign wb_data_o  = res_data_o;

endmodule : result_stage

//--- logic/pipe_core.sv
`timescale 1ns/1ps

module pipe_core import core_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      insn_valid_i,
    input  word_t     insn_i,
    output logic      wb_valid_o,
    output reg_addr_t wb_rd_o,
    output word_t     wb_data_o
);

    // Decode to execute
    issue_if issue ();

    // Register file read path
    reg_addr_t rf_rs1_addr;
    reg_addr_t rf_rs2_addr;
    word_t     rf_rs1_data;
    word_t     rf_rs2_data;

    // Execute output register
    logic      ex_we;
    reg_addr_t ex_rd;
    word_t     ex_data;

    // Result register, older forwarding source
    logic      res_we;
    reg_addr_t res_rd;
    word_t     res_data;

    decode_stage u_decode (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .insn_valid_i  (insn_valid_i),
        .insn_i        (insn_i),
        .rf_rs1_addr_o (rf_rs1_addr),
        .rf_rs2_addr_o (rf_rs2_addr),
        .rf_rs1_data_i (rf_rs1_data),
        .rf_rs2_data_i (rf_rs2_data),
        .issue         (issue.decode)
    );

    execute_stage u_execute (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .issue      (issue.execute),
        .res_we_i   (res_we),
        .res_rd_i   (res_rd),
        .res_data_i (res_data),
        .ex_we_o    (ex_we),
        .ex_rd_o    (ex_rd),
        .ex_data_o  (ex_data)
    );

    result_stage u_result (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .ex_we_i    (ex_we),
        .ex_rd_i    (ex_rd),
        .ex_data_i  (ex_data),
        .rs1_addr_i (rf_rs1_addr),
        .rs2_addr_i (rf_rs2_addr),
        .rs1_data_o (rf_rs1_data),
        .rs2_data_o (rf_rs2_data),
        .res_we_o   (res_we),
        .res_rd_o   (res_rd),
        .res_data_o (res_data),
        .wb_valid_o (wb_valid_o),
        .wb_rd_o    (wb_rd_o),
        .wb_data_o  (wb_data_o)
    );

endmodule : pipe_core

//--- tests/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Architectural register state in program order
logic [31:0] ref_regs [32];

task automatic clear_ref();
    foreach (ref_regs[i]) begin
        ref_regs[i] = '0;
    end
endtask

// R-type word for the OP group
function automatic logic [31:0] encode_r(input logic [6:0] funct7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] funct3,
                                         input logic [4:0] rd);
    return {funct7, rs2, rs1, funct3, rd, OP};
endfunction

// I-type word for the OP-IMM group
function automatic logic [31:0] encode_i(input logic [11:0] imm12, input logic [4:0] rs1,
                                         input logic [2:0] funct3, input logic [4:0] rd);
    return {imm12, rs1, funct3, rd, OP_IMM};
endfunction

// U-type word, LUI only
function automatic logic [31:0] encode_u(input logic [19:0] imm20, input logic [4:0] rd);
    return {imm20, rd, LUI};
endfunction

// Integer operation by funct3, alt picks SUB or SRA
function automatic logic [31:0] alu_ref(input logic [2:0] funct3, input bit alt,
                                        input logic [31:0] a, input logic [31:0] b);
    logic [31:0] res;
    case (funct3)
        F3_ADD_SUB: res = alt ? a - b : a + b;
        F3_SLL:     res = a << b[4:0];
        F3_SLT:     res = {31'b0, $signed(a) < $signed(b)};
        F3_SLTU:    res = {31'b0, a < b};
        F3_XOR:     res = a ^ b;
        F3_SRL_SRA: begin
            // Kept as separate statements so the signed shift stays signed
            if (alt) begin
                res = $signed(a) >>> b[4:0];
            end else begin
                res = a >> b[4:0];
            end
        end
        F3_OR:      res = a | b;
        default:    res = a & b;
    endcase
    return res;
endfunction

// Evaluate one accepted instruction and update the model registers
task automatic run_ref(input logic [31:0] insn, output bit we, output logic [4:0] rd,
                       output logic [31:0] data);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    bit          legal;
    opc   = insn[6:0];
    f3    = insn[14:12];
    f7    = insn[31:25];
    rd    = insn[11:7];
    a     = ref_regs[insn[19:15]];
    b     = ref_regs[insn[24:20]];
    imm   = {{20{insn[31]}}, insn[31:20]};
    legal = 1'b0;
    data  = '0;
    if (opc == OP) begin
        // Alternate funct7 exists only for SUB and SRA
        legal = (f7 == FUNCT7_BASE) ||
                ((f7 == FUNCT7_ALT) && ((f3 == F3_ADD_SUB) || (f3 == F3_SRL_SRA)));
        data  = alu_ref(f3, f7 == FUNCT7_ALT, a, b);
    end else if (opc == OP_IMM) begin
        if (f3 == F3_SLL) begin
            legal = (f7 == FUNCT7_BASE);
        end else if (f3 == F3_SRL_SRA) begin
            legal = (f7 == FUNCT7_BASE) || (f7 == FUNCT7_ALT);
        end else begin
            legal = 1'b1;
        end
        // ADDI never subtracts, whatever imm bit 30 holds
        data = alu_ref(f3, (f3 == F3_SRL_SRA) && (f7 == FUNCT7_ALT), a, imm);
    end else if (opc == LUI) begin
        legal = 1'b1;
        data  = {insn[31:12], 12'b0};
    end
    // x0 is never written
    we = legal && (rd != 5'd0);
    if (we) begin
        ref_regs[rd] = data;
    end
endtask

`endif

//--- tests/tb_pipe_core.sv
`timescale 1ns/1ps

module tb_pipe_core import rv_isa_pkg::*; ();

    localparam time         CLK_PERIOD  = 40ns;
    localparam int unsigned SEED        = 32'h375b7d19;
    localparam int          NUM_INSNS   = 400;
    localparam int          DRAIN_LIMIT = 10;

    logic        clk_i;
    logic        reset_i;
    logic        insn_valid_i;
    logic [31:0] insn_i;
    logic        wb_valid_o;
    logic [4:0]  wb_rd_o;
    logic [31:0] wb_data_o;

    // Expected writes as {rd, data} with the oldest first
    logic [36:0] exp_q [$];
    bit          head_present;
    logic [4:0]  head_rd;
    logic [31:0] head_data;
    // Input on the bus now will write a register
    bit          acc_we;
    // Accepting edges with the newest in bit 0
    bit [2:0]    acc_hist;

    `include "tb_ref_model.svh"

    pipe_core dut (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .insn_valid_i (insn_valid_i),
        .insn_i       (insn_i),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        acc_hist <= {acc_hist[1:0], acc_we};
    end

    task automatic fail_run();
        $display("Errors found");
        $fatal(1, "Simulation stopped on first failure");
    endtask

    task automatic report_value(input string sig, input logic [31:0] expected,
                                input logic [31:0] actual);
        $display("ERROR at %0t: %s expected %h actual %h", $time, sig, expected, actual);
        fail_run();
    endtask

    // Write report exactly three edges after acceptance and never otherwise
    write_timing: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_valid_o == acc_hist[2])
    else report_value("wb_valid_o", 32'($sampled(acc_hist[2])), 32'($sampled(wb_valid_o)));

    // Outputs compared mid-cycle against the oldest expected write
    write_expected: assert property (@(negedge clk_i) disable iff (reset_i)
        wb_valid_o |-> head_present)
    else begin
        $display("Register write to x%0d reported at %0t with none outstanding",
                 $sampled(wb_rd_o), $time);
        fail_run();
    end

    rd_match: assert property (@(negedge clk_i) disable iff (reset_i)
        (wb_valid_o && head_present) |-> (wb_rd_o == head_rd))
    else report_value("wb_rd_o", 32'($sampled(head_rd)), 32'($sampled(wb_rd_o)));

    data_match: assert property (@(negedge clk_i) disable iff (reset_i)
        (wb_valid_o && head_present) |-> (wb_data_o == head_data))
    else report_value("wb_data_o", $sampled(head_data), $sampled(wb_data_o));

    // Small register pool so dependencies at distance 1 to 3 are common
    function automatic logic [4:0] pick_reg();
        return 5'($urandom_range(0, 4));
    endfunction

    function automatic logic [31:0] random_insn();
        logic [31:0] word;
        logic [2:0]  f3;
        logic [11:0] imm12;
        int          kind;
        f3    = 3'($urandom);
        imm12 = 12'($urandom);
        kind  = $urandom_range(0, 19);
        if (kind < 8) begin
            // SUB and SRA on half of the eligible picks
            if (((f3 == F3_ADD_SUB) || (f3 == F3_SRL_SRA)) && ($urandom_range(0, 1) == 1)) begin
                word = encode_r(FUNCT7_ALT, pick_reg(), pick_reg(), f3, pick_reg());
            end else begin
                word = encode_r(FUNCT7_BASE, pick_reg(), pick_reg(), f3, pick_reg());
            end
        end else if (kind < 16) begin
            // Shift immediates need a legal upper field
            if (f3 == F3_SLL) begin
                imm12[11:5] = FUNCT7_BASE;
            end else if (f3 == F3_SRL_SRA) begin
                imm12[11:5] = ($urandom_range(0, 1) == 1) ? FUNCT7_ALT : FUNCT7_BASE;
            end
            word = encode_i(imm12, pick_reg(), f3, pick_reg());
        end else if (kind < 18) begin
            word = encode_u(20'($urandom), pick_reg());
        end else if (kind == 18) begin
            // Load opcode is dropped from this core
            word      = $urandom();
            word[6:0] = 7'b0000011;
        end else begin
            // M extension funct7 is not supported
            word = encode_r(7'b0000001, pick_reg(), pick_reg(), f3, pick_reg());
        end
        return word;
    endfunction

    // Retire a reported write and drive the next input on the falling edge
    task automatic step(input bit valid, input logic [31:0] insn);
        bit          we;
        logic [4:0]  rd;
        logic [31:0] data;
        @(negedge clk_i);
        if (wb_valid_o && (exp_q.size() > 0)) begin
            void'(exp_q.pop_front());
        end
        insn_valid_i = valid;
        insn_i       = insn;
        acc_we       = 1'b0;
        if (valid) begin
            run_ref(insn, we, rd, data);
            acc_we = we;
            if (we) begin
                exp_q.push_back({rd, data});
            end
        end
        head_present = (exp_q.size() > 0);
        if (head_present) begin
            {head_rd, head_data} = exp_q[0];
        end
    endtask

    initial begin
        int waited;
        bit valid;
        void'($urandom(SEED));
        reset_i      = 1'b1;
        insn_valid_i = 1'b0;
        insn_i       = '0;
        acc_we       = 1'b0;
        head_present = 1'b0;
        head_rd      = '0;
        head_data    = '0;
        clear_ref();
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;

        // Idle slots carry garbage words that must not write
        for (int i = 0; i < NUM_INSNS; i++) begin
            valid = ($urandom_range(0, 3) != 0);
            step(valid, valid ? random_insn() : $urandom());
        end

        waited = 0;
        while ((exp_q.size() != 0) && (waited < DRAIN_LIMIT)) begin
            step(1'b0, 32'h0);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Timed out with %0d expected writes never reported", exp_q.size());
            fail_run();
        end else begin
            // Quiet tail so stray writes still get caught
            repeat (4) step(1'b0, 32'h0);
            $display("No errors");
            $finish;
        end
    end

endmodule : tb_pipe_core

//--- all.f
+incdir+tests
logic/rv_isa_pkg.sv
logic/core_pkg.sv
logic/issue_if.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/pipe_core.sv
tests/tb_pipe_core.sv
